// File: div_control.sv
// divider control: run flag, step counter, handshake, cancel and correction sequencing
`timescale 1ns/1ps
`default_nettype none
`include "div_macros.svh"

module div_control import div_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    in_valid,
   output logic    in_ready,
   input  logic    cancel,
   // result still waiting to be read
   input  logic    out_busy,
   input  div_op_e op_q,
   input  logic    acc_neg,
   output logic    load,
   output logic    step,
   output logic    correct,
   output logic    done
);

   localparam logic [`DIV_CNT_W-1:0] last_step = `DIV_CNT_W'(`DIV_STEPS);
   localparam logic [`DIV_CNT_W-1:0] fix_step  = `DIV_CNT_W'(`DIV_STEPS + 1);

   logic                  run;
   logic [`DIV_CNT_W-1:0] cnt;
   logic                  is_rem;
   logic                  at_last;
   logic                  at_fix;

   assign is_rem  = (op_q == op_rem) || (op_q == op_remu);
   assign at_last = (cnt == last_step);
   assign at_fix  = (cnt == fix_step);

   // only one operation in flight, and only once the last result is gone
   assign in_ready = ~run & ~out_busy;

   // cancel in the accept cycle drops the operation
   assign load = in_valid & in_ready & ~cancel;

   // counts 0 .. steps-1 while stepping
   assign step = run & (cnt < last_step);

   // slot after the steps, only used by remainders with a negative accumulator
   assign correct = run & at_last & is_rem & acc_neg;

   // divides finish right after the steps, remainders one slot later
   assign done = run & ~cancel & ((at_last & ~is_rem) | at_fix);

   always_ff @(posedge clk) begin
      if (reset) begin
         run <= 1'b0;
         cnt <= '0;
      end else if (cancel | done) begin
         run <= 1'b0;
         cnt <= '0;
      end else if (load) begin
         run <= 1'b1;
         cnt <= '0;
      end else if (run) begin
         cnt <= cnt + `DIV_CNT_W'(1);
      end
   end

   // counter never runs past the correction slot
   a_cnt_range: assert property (@(posedge clk) disable iff (reset)
      cnt <= fix_step);

   // no new accept while the steps are still running
   a_ready_low_run: assert property (@(posedge clk) disable iff (reset || cancel)
      load |=> !in_ready [*`DIV_STEPS]);

endmodule

`default_nettype wire

// File: div_datapath.sv
// divider datapath: operand, accumulator and quotient registers with the add/subtract step
`timescale 1ns/1ps
`default_nettype none
`include "div_macros.svh"

module div_datapath import div_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  load,
   input  logic                  step,
   input  logic                  correct,
   input  logic [`DIV_WIDTH-1:0] dividend,
   input  logic [`DIV_WIDTH-1:0] divisor,
   input  div_op_e               op,
   output div_op_e               op_q,
   output logic                  acc_neg,
   output logic [`DIV_WIDTH-1:0] quotient,
   output logic [`DIV_WIDTH-1:0] remainder,
   output logic                  dividend_neg,
   output logic                  divisor_neg
);

   // divisor, sign extended to accumulator width
   logic [`DIV_WIDTH:0]   m_q;
   // partial remainder
   logic [`DIV_WIDTH:0]   a_q;
   // dividend shifting out, quotient bits shifting in
   logic [`DIV_WIDTH-1:0] q_q;

   logic                  signed_op;
   logic                  sign_eff;
   logic [`DIV_WIDTH-1:0] dividend_abs;
   logic                  add;
   logic [`DIV_WIDTH:0]   a_base;
   logic [`DIV_WIDTH:0]   m_eff;
   logic [`DIV_WIDTH:0]   a_next;

   assign signed_op = (op == op_div) || (op == op_rem);

   // a zero divisor is handled as unsigned so the raw dividend comes back
   assign sign_eff = signed_op && (divisor != '0);

   assign dividend_abs = (sign_eff & dividend[`DIV_WIDTH-1]) ? -dividend : dividend;

   // negative divisor already carries the sign, so add and subtract swap
   assign add = (a_q[`DIV_WIDTH] | correct) ^ divisor_neg;

   // correction adds the divisor back without a shift
   assign a_base = correct ? a_q : {a_q[`DIV_WIDTH-1:0], q_q[`DIV_WIDTH-1]};

   // subtract as add of the inverse plus one
   assign m_eff  = add ? m_q : ~m_q;
   assign a_next = a_base + m_eff + {{`DIV_WIDTH{1'b0}}, ~add};

   // operation and sign flags
   always_ff @(posedge clk) begin
      if (reset) begin
         op_q         <= op_div;
         dividend_neg <= 1'b0;
         divisor_neg  <= 1'b0;
      end else if (load) begin
         op_q         <= op;
         dividend_neg <= sign_eff & dividend[`DIV_WIDTH-1];
         divisor_neg  <= sign_eff & divisor[`DIV_WIDTH-1];
      end
   end

   // operand capture and one step per cycle
   always_ff @(posedge clk) begin
      if (load) begin
         m_q <= {sign_eff & divisor[`DIV_WIDTH-1], divisor};
         a_q <= '0;
         q_q <= dividend_abs;
      end else if (step) begin
         a_q <= a_next;
         // new quotient bit is the inverted sign of the new remainder
         q_q <= {q_q[`DIV_WIDTH-2:0], ~a_next[`DIV_WIDTH]};
      end else if (correct) begin
         a_q <= a_next;
      end
   end

   assign acc_neg   = a_q[`DIV_WIDTH];
   assign quotient  = q_q;
   assign remainder = a_q[`DIV_WIDTH-1:0];

endmodule

`default_nettype wire

// File: div_macros.svh
// divider width, step count and step counter width macros
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand and result width
`define DIV_WIDTH 32

// one non-restoring step per quotient bit
`define DIV_STEPS 32

// step counter, wide enough for the steps plus the remainder correction slot
`define DIV_CNT_W 6

`endif

// File: div_pkg.sv
// divider package with the divide operation encoding
`default_nettype none

package div_pkg;

   // bit 1 selects remainder, bit 0 selects unsigned
   typedef enum logic [1:0] {
      op_div  = 2'b00,
      op_divu = 2'b01,
      op_rem  = 2'b10,
      op_remu = 2'b11
   } div_op_e;

endpackage

`default_nettype wire

// File: div_result.sv
// divider result: sign fix-up, quotient or remainder select and output holding register
`timescale 1ns/1ps
`default_nettype none
`include "div_macros.svh"

module div_result import div_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  done,
   input  div_op_e               op_q,
   input  logic [`DIV_WIDTH-1:0] quotient,
   input  logic [`DIV_WIDTH-1:0] remainder,
   input  logic                  dividend_neg,
   input  logic                  divisor_neg,
   output logic                  out_valid,
   input  logic                  out_ready,
   output logic                  out_busy,
   output logic [`DIV_WIDTH-1:0] out_data
);

   logic                  signed_op;
   logic                  is_rem;
   logic [`DIV_WIDTH-1:0] q_fix;
   logic [`DIV_WIDTH-1:0] r_fix;
   logic [`DIV_WIDTH-1:0] result;

   assign signed_op = (op_q == op_div) || (op_q == op_rem);
   assign is_rem    = (op_q == op_rem) || (op_q == op_remu);

   // quotient negative when operand signs differ
   assign q_fix = (signed_op & (dividend_neg ^ divisor_neg)) ? -quotient : quotient;

   // remainder takes the sign of the dividend
   assign r_fix = (signed_op & dividend_neg) ? -remainder : remainder;

   assign result = is_rem ? r_fix : q_fix;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (done) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (done) begin
         out_data <= result;
      end
   end

   // keeps new operations out until the result is taken
   assign out_busy = out_valid;

   // held result does not move under back-pressure
   a_hold_stable: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

   // control never finishes on top of an unread result
   a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
      done |-> !out_valid);

endmodule

`default_nettype wire

// File: div_top.sv
// divider top level connecting control, datapath and result stages
`timescale 1ns/1ps
`default_nettype none
`include "div_macros.svh"

module div_top import div_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic                  cancel,
   input  logic [`DIV_WIDTH-1:0] dividend,
   input  logic [`DIV_WIDTH-1:0] divisor,
   input  div_op_e               op,
   output logic                  out_valid,
   input  logic                  out_ready,
   output logic [`DIV_WIDTH-1:0] out_data
);

   logic                  load;
   logic                  step;
   logic                  correct;
   logic                  done;
   logic                  out_busy;
   div_op_e               op_q;
   logic                  acc_neg;
   logic [`DIV_WIDTH-1:0] quotient;
   logic [`DIV_WIDTH-1:0] remainder;
   logic                  dividend_neg;
   logic                  divisor_neg;

   div_control u_div_control (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .cancel   (cancel),
      .out_busy (out_busy),
      .op_q     (op_q),
      .acc_neg  (acc_neg),
      .load     (load),
      .step     (step),
      .correct  (correct),
      .done     (done)
   );

   div_datapath u_div_datapath (
      .clk          (clk),
      .reset        (reset),
      .load         (load),
      .step         (step),
      .correct      (correct),
      .dividend     (dividend),
      .divisor      (divisor),
      .op           (op),
      .op_q         (op_q),
      .acc_neg      (acc_neg),
      .quotient     (quotient),
      .remainder    (remainder),
      .dividend_neg (dividend_neg),
      .divisor_neg  (divisor_neg)
   );

   div_result u_div_result (
      .clk          (clk),
      .reset        (reset),
      .done         (done),
      .op_q         (op_q),
      .quotient     (quotient),
      .remainder    (remainder),
      .dividend_neg (dividend_neg),
      .divisor_neg  (divisor_neg),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_busy     (out_busy),
      .out_data     (out_data)
   );

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
div_pkg.sv
div_control.sv
div_datapath.sv
div_result.sv
div_top.sv
tb_div.sv

// File: tb_div.sv
// random testbench for the divider with a reference model, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none
`include "div_macros.svh"

module tb_div import div_pkg::*; ();

   localparam int n_corner     = 20;
   localparam int n_random     = 400;
   localparam int n_ops        = n_corner + n_random;
   localparam int max_stall    = 6;
   localparam int max_gap      = 3;
   localparam int drain_cycles = 50;
   localparam int cycle_limit  = n_ops * (40 + max_stall + max_gap) + drain_cycles + 100;
   localparam logic [`DIV_WIDTH-1:0] min_neg = {1'b1, {(`DIV_WIDTH-1){1'b0}}};
   localparam logic [`DIV_WIDTH-1:0] max_pos = {1'b0, {(`DIV_WIDTH-1){1'b1}}};

   logic                  clk;
   logic                  reset;
   logic                  in_valid;
   logic                  in_ready;
   logic                  cancel;
   logic [`DIV_WIDTH-1:0] dividend;
   logic [`DIV_WIDTH-1:0] divisor;
   div_op_e               op;
   logic                  out_valid;
   logic                  out_ready;
   logic [`DIV_WIDTH-1:0] out_data;

   // expected results, at most one outstanding
   logic [`DIV_WIDTH-1:0] exp_q[$];
   div_op_e               exp_op_q[$];
   string                 exp_name_q[$];

   logic [`DIV_WIDTH-1:0] corner_a [0:4];
   logic [`DIV_WIDTH-1:0] corner_b [0:4];

   // operation waiting on the input side
   logic                  pending;
   logic [`DIV_WIDTH-1:0] pend_a;
   logic [`DIV_WIDTH-1:0] pend_b;
   div_op_e               pend_op;
   string                 pend_name;

   logic                  inflight;
   logic                  held;
   logic [`DIV_WIDTH-1:0] held_data;
   div_op_e               held_op;
   int                    accept_cyc;
   int                    cancel_cyc;
   int                    issued;
   int                    gap;
   int                    stall;
   int                    cyc = 0;

   int                    err_data;
   int                    err_lat;
   int                    err_proto;
   int                    n_checked;
   int                    n_cancel;
   int                    n_drop;

   div_top u_div_top (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .cancel    (cancel),
      .dividend  (dividend),
      .divisor   (divisor),
      .op        (op),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   always @(negedge clk) begin
      if (cyc > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // RISC-V M result rules
   function automatic logic [`DIV_WIDTH-1:0] model_result(div_op_e f,
                                                         logic [`DIV_WIDTH-1:0] a,
                                                         logic [`DIV_WIDTH-1:0] b);
      logic signed [`DIV_WIDTH-1:0] sa;
      logic signed [`DIV_WIDTH-1:0] sb;
      logic                         ovf;
      sa  = a;
      sb  = b;
      ovf = (a == min_neg) && (b == '1);
      case (f)
         op_divu: model_result = (b == '0) ? '1 : a / b;
         op_remu: model_result = (b == '0) ? a : a % b;
         op_div: begin
            if (b == '0) begin
               model_result = '1;
            end else if (ovf) begin
               model_result = min_neg;
            end else begin
               model_result = sa / sb;
            end
         end
         default: begin
            if (b == '0) begin
               model_result = a;
            end else if (ovf) begin
               model_result = '0;
            end else begin
               model_result = sa % sb;
            end
         end
      endcase
   endfunction

   // mix of small, special and full range values
   function automatic logic [`DIV_WIDTH-1:0] rand_operand();
      logic [`DIV_WIDTH-1:0] v;
      case ($urandom_range(0, 5))
         0: v = `DIV_WIDTH'($urandom_range(0, 255));
         1: begin
            v = `DIV_WIDTH'($urandom_range(1, 255));
            v = -v;
         end
         2: begin
            case ($urandom_range(0, 4))
               0: v = '0;
               1: v = `DIV_WIDTH'(1);
               2: v = '1;
               3: v = min_neg;
               default: v = max_pos;
            endcase
         end
         default: v = $urandom;
      endcase
      return v;
   endfunction

   task automatic check_data(input string name, input logic [`DIV_WIDTH-1:0] exp,
                             input logic [`DIV_WIDTH-1:0] act, input div_op_e f);
      if (act !== exp) begin
         err_data++;
         $display("FAILED %s %s: expected %h, actual %h", name, f.name(), exp, act);
      end
   endtask

   task automatic check_latency(input string name, input int exp, input int act,
                                input div_op_e f);
      if (act != exp) begin
         err_lat++;
         $display("FAILED %s %s latency: expected %0d, actual %0d", name, f.name(), exp, act);
      end
   endtask

   task automatic protocol_error(input string msg);
      err_proto++;
      $display("protocol error at cycle %0d: %s", cyc, msg);
   endtask

   // corner pairs first, then random operands
   task automatic prepare_operation();
      int idx;
      if (issued < n_corner) begin
         idx       = issued / 4;
         pend_a    = corner_a[idx];
         pend_b    = corner_b[idx];
         pend_op   = div_op_e'(issued % 4);
         pend_name = "corner";
      end else begin
         pend_a    = rand_operand();
         pend_b    = rand_operand();
         pend_op   = div_op_e'($urandom_range(0, 3));
         pend_name = "random";
      end
      issued++;
      pending = 1'b1;
   endtask

   // one clock cycle: observe at the falling edge, then drive the next inputs
   task automatic cycle_step();
      logic                  rdy;
      logic                  ov;
      logic [`DIV_WIDTH-1:0] od;
      logic [`DIV_WIDTH-1:0] e_data;
      div_op_e               e_op;
      string                 e_name;
      int                    lat;
      @(negedge clk);
      rdy = in_ready;
      ov  = out_valid;
      od  = out_data;

      if (ov && !held) begin
         if (exp_q.size() == 0) begin
            protocol_error("out_valid high with no result expected");
         end else begin
            e_data = exp_q.pop_front();
            e_op   = exp_op_q.pop_front();
            e_name = exp_name_q.pop_front();
            lat    = (e_op == op_rem || e_op == op_remu) ? 35 : 34;
            check_latency(e_name, lat, cyc - accept_cyc, e_op);
            check_data(e_name, e_data, od, e_op);
            held_op = e_op;
            n_checked++;
         end
         inflight  = 1'b0;
         held      = 1'b1;
         held_data = od;
      end else if (ov && held) begin
         check_data("hold", held_data, od, held_op);
      end else if (!ov && held) begin
         protocol_error("out_valid dropped before the result was read");
         held = 1'b0;
      end

      if (rdy && (inflight || held)) begin
         protocol_error("in_ready high while an operation runs or a result is held");
      end
      if (!rdy && !inflight && !held) begin
         protocol_error("in_ready low while the divider is idle");
      end

      // output side, stalls bounded so the run length is known
      if (held && stall >= max_stall) begin
         out_ready = 1'b1;
      end else begin
         out_ready = ($urandom_range(0, 2) != 0);
      end
      if (held && out_ready) begin
         held  = 1'b0;
         stall = 0;
      end else if (held) begin
         stall++;
      end

      // input side
      if (!pending && issued < n_ops) begin
         if (gap > 0) begin
            gap--;
         end else begin
            prepare_operation();
         end
      end
      in_valid = pending;
      if (pending) begin
         dividend = pend_a;
         divisor  = pend_b;
         op       = pend_op;
      end else begin
         dividend = $urandom;
         divisor  = $urandom;
         op       = div_op_e'($urandom_range(0, 3));
      end

      if (inflight && cyc == cancel_cyc) begin
         cancel   = 1'b1;
         inflight = 1'b0;
         void'(exp_q.pop_back());
         void'(exp_op_q.pop_back());
         void'(exp_name_q.pop_back());
         n_cancel++;
      end else if (pending && rdy) begin
         // corner operations always run to completion
         if (issued > n_corner && $urandom_range(0, 15) == 0) begin
            // dropped in the accept cycle
            cancel  = 1'b1;
            pending = 1'b0;
            gap     = $urandom_range(0, max_gap);
            n_drop++;
         end else begin
            cancel = 1'b0;
            exp_q.push_back(model_result(pend_op, pend_a, pend_b));
            exp_op_q.push_back(pend_op);
            exp_name_q.push_back(pend_name);
            held_op    = pend_op;
            accept_cyc = cyc;
            inflight   = 1'b1;
            pending    = 1'b0;
            gap        = $urandom_range(0, max_gap);
            lat        = (pend_op == op_rem || pend_op == op_remu) ? 35 : 34;
            if (issued > n_corner && $urandom_range(0, 7) == 0) begin
               cancel_cyc = cyc + 1 + $urandom_range(0, lat - 2);
            end else begin
               cancel_cyc = -1;
            end
         end
      end else begin
         // harmless cancel pulses while nothing runs
         cancel = !inflight && ($urandom_range(0, 31) == 0);
      end
   endtask

   initial begin
      int seed_val;
      reset     = 1'b1;
      in_valid  = 1'b0;
      cancel    = 1'b0;
      dividend  = '0;
      divisor   = '0;
      op        = op_div;
      out_ready = 1'b0;

      pending    = 1'b0;
      inflight   = 1'b0;
      held       = 1'b0;
      held_data  = '0;
      held_op    = op_div;
      accept_cyc = 0;
      cancel_cyc = -1;
      issued     = 0;
      gap        = 0;
      stall      = 0;
      err_data   = 0;
      err_lat    = 0;
      err_proto  = 0;
      n_checked  = 0;
      n_cancel   = 0;
      n_drop     = 0;

      // zero divisor, overflow, all ones, zero dividend
      corner_a[0] = 32'h1234_5678;
      corner_b[0] = '0;
      corner_a[1] = min_neg;
      corner_b[1] = '1;
      corner_a[2] = '1;
      corner_b[2] = '1;
      corner_a[3] = '0;
      corner_b[3] = 32'h0000_0007;
      corner_a[4] = min_neg;
      corner_b[4] = '0;

      seed_val = $urandom(32'h1bc8735b);

      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      while (issued < n_ops || pending || inflight || held) begin
         cycle_step();
      end
      // late results of cancelled operations would show up here
      repeat (drain_cycles) cycle_step();

      $display("errors: data %0d, latency %0d, protocol %0d (results %0d, cancels %0d, drops %0d)",
               err_data, err_lat, err_proto, n_checked, n_cancel, n_drop);
      if (err_data + err_lat + err_proto == 0 && n_checked > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
